// ==== include/fsp_settings.svh ====
// binary64 and NaN-boxed binary32 only; depth and credit counts must stay at least 1
`ifndef FSP_SETTINGS_SVH
`define FSP_SETTINGS_SVH

// --------------------
// datapath
// --------------------
`define FSP_DATA_W 64

// --------------------
// flow control
// --------------------
// result FIFO entries and the number of input credits
`define FSP_BUF_DEPTH 4
// credits granted by the downstream at reset
`define FSP_OUT_CREDITS 2

// --------------------
// canonical NaN words
// --------------------
`define FSP_CNAN_D 64'h7FF8_0000_0000_0000
// single NaN boxed with ones in the upper half
`define FSP_CNAN_S 64'hFFFF_FFFF_7FC0_0000

`endif

// ==== src/fsp_format_pkg.sv ====
// describes binary64 and boxed binary32 words only; half formats are not modelled
package fsp_format_pkg;

  // --------------------
  // format select
  // --------------------
  typedef enum logic {
    fmt_d = 1'b0,
    fmt_s = 1'b1
  } fsp_fmt_e;

  // --------------------
  // operand views
  // --------------------
  // binary64 layout
  typedef struct packed {
    logic        sign;
    logic [10:0] exp;
    logic [51:0] frac;
  } fsp_double_t;

  // binary32 in the low half of the word
  typedef struct packed {
    logic [31:0] box;
    logic        sign;
    logic [7:0]  exp;
    logic [22:0] frac;
  } fsp_single_t;

  // one 64-bit word, read as double or as single
  typedef union packed {
    fsp_double_t d;
    fsp_single_t s;
  } fsp_operand_u;

  // --------------------
  // operand class
  // --------------------
  // at most one bit set, all zero for a finite non-zero value
  typedef struct packed {
    logic snan;
    logic qnan;
    logic inf;
    logic zero;
  } fsp_class_t;

endpackage

// ==== src/fsp_op_pkg.sv ====
// encodings are shared with the vector file, so codes must not be renumbered
package fsp_op_pkg;

  // --------------------
  // operation code
  // --------------------
  typedef enum logic [2:0] {
    op_add = 3'd0,
    op_sub = 3'd1,
    op_max = 3'd2,
    op_min = 3'd3,
    op_feq = 3'd4,
    op_flt = 3'd5,
    op_fle = 3'd6
  } fsp_op_e;

  // --------------------
  // special-result kind
  // --------------------
  // none means the main adder owns the result
  typedef enum logic [2:0] {
    kind_none = 3'd0,
    kind_src0 = 3'd1,
    kind_src1 = 3'd2,
    kind_cnan = 3'd3,
    kind_inf  = 3'd4,
    kind_cmp  = 3'd5
  } fsp_kind_e;

endpackage

// ==== src/fsp_classify.sv ====
// single operands are classified from the low 32 bits only; the NaN box is not checked
`timescale 1ns/10ps

module fsp_classify (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         in_valid,
  input  fsp_op_pkg::fsp_op_e          in_op,
  input  fsp_format_pkg::fsp_fmt_e     in_fmt,
  input  fsp_format_pkg::fsp_operand_u in_src0,
  input  fsp_format_pkg::fsp_operand_u in_src1,
  output logic                         c_valid,
  output fsp_op_pkg::fsp_op_e          c_op,
  output fsp_format_pkg::fsp_fmt_e     c_fmt,
  output fsp_format_pkg::fsp_operand_u c_src0,
  output fsp_format_pkg::fsp_operand_u c_src1,
  output fsp_format_pkg::fsp_class_t   c_cls0,
  output fsp_format_pkg::fsp_class_t   c_cls1
);

  import fsp_format_pkg::*;

  fsp_class_t cls0;
  fsp_class_t cls1;

  // decode one operand through the view picked by the format
  function automatic fsp_class_t classify_word(input fsp_operand_u w, input fsp_fmt_e fmt);
    logic       exp_ones;
    logic       exp_zero;
    logic       frac_zero;
    logic       frac_msb;
    fsp_class_t cls;
    if (fmt == fmt_s)
    begin
      exp_ones  = &w.s.exp;
      exp_zero  = ~|w.s.exp;
      frac_zero = ~|w.s.frac;
      frac_msb  = w.s.frac[22];
    end
    else
    begin
      exp_ones  = &w.d.exp;
      exp_zero  = ~|w.d.exp;
      frac_zero = ~|w.d.frac;
      frac_msb  = w.d.frac[51];
    end
    // quiet bit set means qnan, the rest of a nonzero fraction means snan
    cls.snan = exp_ones & ~frac_zero & ~frac_msb;
    cls.qnan = exp_ones & frac_msb;
    cls.inf  = exp_ones & frac_zero;
    cls.zero = exp_zero & frac_zero;
    return cls;
  endfunction

  assign cls0 = classify_word(in_src0, in_fmt);
  assign cls1 = classify_word(in_src1, in_fmt);

  // --------------------
  // stage 1 registers
  // --------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      c_valid <= 1'b0;
    else
      c_valid <= in_valid;
  end

  always_ff @(posedge clk)
  begin
    c_op   <= in_op;
    c_fmt  <= in_fmt;
    c_src0 <= in_src0;
    c_src1 <= in_src1;
    c_cls0 <= cls0;
    c_cls1 <= cls1;
  end

  // resolve relies on classes being exclusive
  a_class_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    c_valid |-> ($onehot0(c_cls0) && $onehot0(c_cls1)))
    else $error("operand class bits not one-hot");

endmodule

// ==== src/fsp_resolve.sv ====
// always picks the canonical NaN; NaN payloads are never propagated
`timescale 1ns/10ps

module fsp_resolve (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         c_valid,
  input  fsp_op_pkg::fsp_op_e          c_op,
  input  fsp_format_pkg::fsp_fmt_e     c_fmt,
  input  fsp_format_pkg::fsp_operand_u c_src0,
  input  fsp_format_pkg::fsp_operand_u c_src1,
  input  fsp_format_pkg::fsp_class_t   c_cls0,
  input  fsp_format_pkg::fsp_class_t   c_cls1,
  output logic                         r_valid,
  output fsp_op_pkg::fsp_kind_e        r_kind,
  output logic                         r_sign,
  output logic                         r_cmp,
  output logic                         r_nv,
  output fsp_format_pkg::fsp_fmt_e     r_fmt,
  output fsp_format_pkg::fsp_operand_u r_src0,
  output fsp_format_pkg::fsp_operand_u r_src1
);

  import fsp_format_pkg::*;
  import fsp_op_pkg::*;

  logic      s0;
  logic      s1;
  logic      nan0;
  logic      nan1;
  logic      any_snan;
  logic      any_inf;
  logic      act_sub;
  logic      pos_inf;
  logic      neg_inf;
  logic      feq_inf;
  logic      flt_inf;
  fsp_kind_e kind;
  logic      sign;
  logic      cmp;
  logic      nv;

  assign s0 = (c_fmt == fmt_s) ? c_src0.s.sign : c_src0.d.sign;
  assign s1 = (c_fmt == fmt_s) ? c_src1.s.sign : c_src1.d.sign;

  assign nan0     = c_cls0.snan | c_cls0.qnan;
  assign nan1     = c_cls1.snan | c_cls1.qnan;
  assign any_snan = c_cls0.snan | c_cls1.snan;
  assign any_inf  = c_cls0.inf | c_cls1.inf;

  // sub flips the sign of src1
  assign act_sub = s0 ^ s1 ^ (c_op == op_sub);

  assign pos_inf = (c_cls0.inf & ~s0) | (c_cls1.inf & ~s1);
  assign neg_inf = (c_cls0.inf & s0) | (c_cls1.inf & s1);

  // --------------------
  // compare with infinities
  // --------------------
  assign feq_inf = c_cls0.inf & c_cls1.inf & (s0 == s1);

  always_comb
  begin
    if (c_cls0.inf && c_cls1.inf)
      flt_inf = s0 & ~s1;
    else if (c_cls0.inf)
      flt_inf = s0;
    else
      flt_inf = ~s1;
  end

  // --------------------
  // per-operation rules
  // --------------------
  always_comb
  begin
    kind = kind_none;
    sign = 1'b0;
    cmp  = 1'b0;
    nv   = 1'b0;
    case (c_op)
      op_add, op_sub:
      begin
        if (nan0 || nan1)
        begin
          kind = kind_cnan;
          nv   = any_snan;
        end
        else if (c_cls0.inf && c_cls1.inf && act_sub)
        begin
          // inf - inf
          kind = kind_cnan;
          nv   = 1'b1;
        end
        else if (c_cls0.inf)
        begin
          kind = kind_inf;
          sign = s0;
        end
        else if (c_cls1.inf)
        begin
          kind = kind_inf;
          sign = s1 ^ (c_op == op_sub);
        end
      end
      op_max, op_min:
      begin
        if (any_snan || (nan0 && nan1))
        begin
          kind = kind_cnan;
          nv   = any_snan;
        end
        else if (nan0)
          kind = kind_src1;
        else if (nan1)
          kind = kind_src0;
        else if (any_inf)
        begin
          // max wants a +inf, min a -inf, otherwise the other operand wins
          if ((c_op == op_max) ? pos_inf : neg_inf)
          begin
            kind = kind_inf;
            sign = (c_op == op_min);
          end
          else
            kind = c_cls0.inf ? kind_src1 : kind_src0;
        end
      end
      op_feq, op_flt, op_fle:
      begin
        if (nan0 || nan1)
        begin
          kind = kind_cmp;
          nv   = (c_op == op_feq) ? any_snan : 1'b1;
        end
        else if (any_inf)
        begin
          kind = kind_cmp;
          if (c_op == op_feq)
            cmp = feq_inf;
          else if (c_op == op_flt)
            cmp = flt_inf;
          else
            cmp = feq_inf | flt_inf;
        end
      end
      default:
      begin
        kind = kind_none;
      end
    endcase
  end

  // --------------------
  // stage 2 registers
  // --------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      r_valid <= 1'b0;
    else
      r_valid <= c_valid;
  end

  always_ff @(posedge clk)
  begin
    r_kind <= kind;
    r_sign <= sign;
    r_cmp  <= cmp;
    r_nv   <= nv;
    r_fmt  <= c_fmt;
    r_src0 <= c_src0;
    r_src1 <= c_src1;
  end

  // a special input must never fall through to the main adder
  a_none_is_normal: assert property (@(posedge clk) disable iff (!rst_n)
    (r_valid && r_kind == kind_none) |-> !$past(nan0 || nan1 || any_inf))
    else $error("special operand resolved to kind none");

endmodule

// ==== src/fsp_assemble.sv ====
// single results other than passed operands are boxed with ones in the upper half
`timescale 1ns/10ps

`include "fsp_settings.svh"

module fsp_assemble (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         r_valid,
  input  fsp_op_pkg::fsp_kind_e        r_kind,
  input  logic                         r_sign,
  input  logic                         r_cmp,
  input  logic                         r_nv,
  input  fsp_format_pkg::fsp_fmt_e     r_fmt,
  input  fsp_format_pkg::fsp_operand_u r_src0,
  input  fsp_format_pkg::fsp_operand_u r_src1,
  output logic                         a_valid,
  output fsp_format_pkg::fsp_operand_u a_data,
  output logic                         a_nv,
  output logic                         a_special
);

  import fsp_format_pkg::*;
  import fsp_op_pkg::*;

  localparam int DATA_W = `FSP_DATA_W;

  fsp_operand_u word;

  // --------------------
  // result word
  // --------------------
  always_comb
  begin
    word = '0;
    case (r_kind)
      kind_src0: word = r_src0;
      kind_src1: word = r_src1;
      kind_cnan:
      begin
        if (r_fmt == fmt_s)
          word = fsp_operand_u'(`FSP_CNAN_S);
        else
          word = fsp_operand_u'(`FSP_CNAN_D);
      end
      kind_inf:
      begin
        if (r_fmt == fmt_s)
        begin
          word.s.box  = '1;
          word.s.sign = r_sign;
          word.s.exp  = '1;
          word.s.frac = '0;
        end
        else
        begin
          word.d.sign = r_sign;
          word.d.exp  = '1;
          word.d.frac = '0;
        end
      end
      // compare result in bit 0
      kind_cmp: word = fsp_operand_u'({{(DATA_W - 1){1'b0}}, r_cmp});
      default: word = '0;
    endcase
  end

  // --------------------
  // stage 3 registers
  // --------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      a_valid <= 1'b0;
    else
      a_valid <= r_valid;
  end

  always_ff @(posedge clk)
  begin
    a_data    <= word;
    a_nv      <= r_nv;
    a_special <= (r_kind != kind_none);
  end

endmodule

// ==== src/fsp_result_buffer.sv ====
// upstream must send only against in_credit and downstream must return only spent credits
`timescale 1ns/10ps

`include "fsp_settings.svh"

module fsp_result_buffer (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         a_valid,
  input  fsp_format_pkg::fsp_operand_u a_data,
  input  logic                         a_nv,
  input  logic                         a_special,
  input  logic                         out_credit,
  output logic                         out_valid,
  output fsp_format_pkg::fsp_operand_u out_data,
  output logic                         out_nv,
  output logic                         out_special,
  output logic                         in_credit
);

  import fsp_format_pkg::*;

  localparam int DEPTH       = `FSP_BUF_DEPTH;
  localparam int OUT_CREDITS = `FSP_OUT_CREDITS;
  localparam int PTR_W       = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W       = $clog2(DEPTH + 1);
  localparam int CRED_W      = $clog2(OUT_CREDITS + 1);

  fsp_operand_u      mem_data    [DEPTH];
  logic              mem_nv      [DEPTH];
  logic              mem_special [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic [CRED_W-1:0] out_cred;
  // input credits still to be handed upstream
  logic [CNT_W-1:0]  owed;
  logic              wr_en;
  logic              rd_en;

  assign wr_en = a_valid;
  assign rd_en = (count != '0) && (out_cred != '0);

  assign out_valid   = rd_en;
  assign out_data    = mem_data[rd_ptr];
  assign out_nv      = mem_nv[rd_ptr];
  assign out_special = mem_special[rd_ptr];

  // --------------------
  // storage
  // --------------------
  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      mem_data[wr_ptr]    <= a_data;
      mem_nv[wr_ptr]      <= a_nv;
      mem_special[wr_ptr] <= a_special;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
      if (rd_en)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
      case ({wr_en, rd_en})
        2'b10: count <= count + CNT_W'(1);
        2'b01: count <= count - CNT_W'(1);
        default: count <= count;
      endcase
    end
  end

  // --------------------
  // credits
  // --------------------
  // owed starts full so the initial credits go out one per cycle,
  // then each read queues one more
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      out_cred  <= CRED_W'(OUT_CREDITS);
      owed      <= CNT_W'(DEPTH);
      in_credit <= 1'b0;
    end
    else
    begin
      case ({rd_en, out_credit})
        2'b10: out_cred <= out_cred - CRED_W'(1);
        2'b01: out_cred <= out_cred + CRED_W'(1);
        default: out_cred <= out_cred;
      endcase
      in_credit <= (owed != '0);
      owed      <= owed - CNT_W'(owed != '0) + CNT_W'(rd_en);
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    a_valid |-> (count < CNT_W'(DEPTH)))
    else $error("result written into a full buffer");

  // downstream returns at most what it was given
  a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
    out_credit |-> ((out_cred < CRED_W'(OUT_CREDITS)) || rd_en))
    else $error("output credit returned beyond the granted count");

endmodule

// ==== src/fsp_special_top.sv ====
// fixed three-cycle path to the buffer; output latency depends on out_credit returns
`timescale 1ns/10ps

module fsp_special_top (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         in_valid,
  input  fsp_op_pkg::fsp_op_e          in_op,
  input  fsp_format_pkg::fsp_fmt_e     in_fmt,
  input  fsp_format_pkg::fsp_operand_u in_src0,
  input  fsp_format_pkg::fsp_operand_u in_src1,
  output logic                         in_credit,
  output logic                         out_valid,
  output fsp_format_pkg::fsp_operand_u out_data,
  output logic                         out_nv,
  output logic                         out_special,
  input  logic                         out_credit
);

  import fsp_format_pkg::*;
  import fsp_op_pkg::*;

  // --------------------
  // stage 1 to 2
  // --------------------
  logic         c_valid;
  fsp_op_e      c_op;
  fsp_fmt_e     c_fmt;
  fsp_operand_u c_src0;
  fsp_operand_u c_src1;
  fsp_class_t   c_cls0;
  fsp_class_t   c_cls1;

  // --------------------
  // stage 2 to 3
  // --------------------
  logic         r_valid;
  fsp_kind_e    r_kind;
  logic         r_sign;
  logic         r_cmp;
  logic         r_nv;
  fsp_fmt_e     r_fmt;
  fsp_operand_u r_src0;
  fsp_operand_u r_src1;

  // stage 3 into the buffer
  logic         a_valid;
  fsp_operand_u a_data;
  logic         a_nv;
  logic         a_special;

  fsp_classify u_classify (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_op    (in_op),
    .in_fmt   (in_fmt),
    .in_src0  (in_src0),
    .in_src1  (in_src1),
    .c_valid  (c_valid),
    .c_op     (c_op),
    .c_fmt    (c_fmt),
    .c_src0   (c_src0),
    .c_src1   (c_src1),
    .c_cls0   (c_cls0),
    .c_cls1   (c_cls1)
  );

  fsp_resolve u_resolve (
    .clk     (clk),
    .rst_n   (rst_n),
    .c_valid (c_valid),
    .c_op    (c_op),
    .c_fmt   (c_fmt),
    .c_src0  (c_src0),
    .c_src1  (c_src1),
    .c_cls0  (c_cls0),
    .c_cls1  (c_cls1),
    .r_valid (r_valid),
    .r_kind  (r_kind),
    .r_sign  (r_sign),
    .r_cmp   (r_cmp),
    .r_nv    (r_nv),
    .r_fmt   (r_fmt),
    .r_src0  (r_src0),
    .r_src1  (r_src1)
  );

  fsp_assemble u_assemble (
    .clk       (clk),
    .rst_n     (rst_n),
    .r_valid   (r_valid),
    .r_kind    (r_kind),
    .r_sign    (r_sign),
    .r_cmp     (r_cmp),
    .r_nv      (r_nv),
    .r_fmt     (r_fmt),
    .r_src0    (r_src0),
    .r_src1    (r_src1),
    .a_valid   (a_valid),
    .a_data    (a_data),
    .a_nv      (a_nv),
    .a_special (a_special)
  );

  fsp_result_buffer u_result_buffer (
    .clk         (clk),
    .rst_n       (rst_n),
    .a_valid     (a_valid),
    .a_data      (a_data),
    .a_nv        (a_nv),
    .a_special   (a_special),
    .out_credit  (out_credit),
    .out_valid   (out_valid),
    .out_data    (out_data),
    .out_nv      (out_nv),
    .out_special (out_special),
    .in_credit   (in_credit)
  );

endmodule

// ==== test/tb_fsp_special.sv ====
// reads test/fsp_vectors.hex from the project root, at most 64 vectors ended by an all-ones op word
`timescale 1ns/10ps

`include "fsp_settings.svh"

module tb_fsp_special;

  import fsp_format_pkg::*;
  import fsp_op_pkg::*;

  localparam int VEC_MAX    = 64;
  localparam int VEC_WORDS  = 7;
  localparam int RST_CYCLES = 10;

  logic         clk;
  logic         rst_n;
  logic         in_valid;
  fsp_op_e      in_op;
  fsp_fmt_e     in_fmt;
  fsp_operand_u in_src0;
  fsp_operand_u in_src1;
  logic         in_credit;
  logic         out_valid;
  fsp_operand_u out_data;
  logic         out_nv;
  logic         out_special;
  logic         out_credit;

  // op, fmt, src0, src1, data, nv, special per vector
  logic [63:0]  vec_mem [VEC_MAX*VEC_WORDS];

  // expected results in input order
  fsp_operand_u exp_data_q [$];
  logic         exp_nv_q [$];
  logic         exp_sp_q [$];

  integer seed = 32'h9393_87fc;
  int     num_vec;
  int     sent;
  int     received;
  int     errors;
  int     cycles;
  int     limit;
  int     credits;
  int     pending;
  int     hold;
  bit     timed_out;

  fsp_special_top DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_op       (in_op),
    .in_fmt      (in_fmt),
    .in_src0     (in_src0),
    .in_src1     (in_src1),
    .in_credit   (in_credit),
    .out_valid   (out_valid),
    .out_data    (out_data),
    .out_nv      (out_nv),
    .out_special (out_special),
    .out_credit  (out_credit)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------
  // compare tasks
  // --------------------
  task automatic check_data(input int idx, input fsp_operand_u got, input fsp_operand_u exp,
                            output bit ok);
    ok = (got == exp);
    if (!ok)
    begin
      errors++;
      $display("error at %0t: vector %0d data %h, expected %h", $time, idx, got, exp);
    end
  endtask

  task automatic check_flags(input int idx, input logic got_nv, input logic got_sp,
                             input logic exp_nv, input logic exp_sp, output bit ok);
    ok = (got_nv == exp_nv) && (got_sp == exp_sp);
    if (!ok)
    begin
      errors++;
      $display("error at %0t: vector %0d nv %b special %b, expected nv %b special %b",
               $time, idx, got_nv, got_sp, exp_nv, exp_sp);
    end
  endtask

  task automatic take_result();
    fsp_operand_u e_data;
    logic         e_nv;
    logic         e_sp;
    bit           data_ok;
    bit           flags_ok;
    if (exp_data_q.size() == 0)
    begin
      errors++;
      $display("a result arrived at %0t with no request outstanding", $time);
    end
    else
    begin
      e_data = exp_data_q.pop_front();
      e_nv   = exp_nv_q.pop_front();
      e_sp   = exp_sp_q.pop_front();
      check_data(received, out_data, e_data, data_ok);
      check_flags(received, out_nv, out_special, e_nv, e_sp, flags_ok);
      $display("vector %0d: %s", received, (data_ok && flags_ok) ? "ok" : "mismatch");
      received++;
    end
  endtask

  task automatic send_vector(input int n);
    int b;
    b = n * VEC_WORDS;
    in_valid <= 1'b1;
    in_op    <= fsp_op_e'(vec_mem[b][2:0]);
    in_fmt   <= fsp_fmt_e'(vec_mem[b+1][0]);
    in_src0  <= fsp_operand_u'(vec_mem[b+2]);
    in_src1  <= fsp_operand_u'(vec_mem[b+3]);
    exp_data_q.push_back(fsp_operand_u'(vec_mem[b+4]));
    exp_nv_q.push_back(vec_mem[b+5][0]);
    exp_sp_q.push_back(vec_mem[b+6][0]);
  endtask

  // outputs sampled mid-cycle, inputs driven on the rising edge
  task automatic run_cycle();
    bit send_now;
    bit ret_now;
    @(negedge clk);
    cycles++;
    if (in_credit)
      credits++;
    if (credits > `FSP_BUF_DEPTH)
    begin
      errors++;
      $display("more input credits held than the result buffer has entries");
    end
    if (out_valid)
    begin
      pending++;
      take_result();
    end
    send_now = (credits > 0) && (sent < num_vec);
    ret_now  = 1'b0;
    // spent output credits go back after a random gap
    if (hold > 0)
      hold--;
    else if (pending > 0)
    begin
      ret_now = 1'b1;
      pending--;
      hold = $random(seed) & 7;
    end
    @(posedge clk);
    if (send_now)
    begin
      send_vector(sent);
      sent++;
      credits--;
    end
    else
      in_valid <= 1'b0;
    out_credit <= ret_now;
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial
  begin
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_op      = op_add;
    in_fmt     = fmt_d;
    in_src0    = '0;
    in_src1    = '0;
    out_credit = 1'b0;
    num_vec    = 0;
    sent       = 0;
    received   = 0;
    errors     = 0;
    cycles     = 0;
    credits    = 0;
    pending    = 0;
    hold       = 0;
    timed_out  = 1'b0;
    // entries past the file keep the all-ones end marker
    for (int i = 0; i < VEC_MAX * VEC_WORDS; i++)
      vec_mem[i] = '1;
    $readmemh("test/fsp_vectors.hex", vec_mem);
    while (num_vec < VEC_MAX && vec_mem[num_vec * VEC_WORDS] != '1)
      num_vec++;
    limit = RST_CYCLES + 40 * num_vec;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    while (received < num_vec && !timed_out)
    begin
      run_cycle();
      if (received < num_vec && cycles >= limit)
        timed_out = 1'b1;
    end
    // idle tail where any late beat is a duplicate
    if (!timed_out)
      repeat (20) run_cycle();
    if (num_vec == 0)
    begin
      errors++;
      $display("no vectors were read from the vector file");
    end
    if (timed_out)
      $display("timeout after %0d cycles, %0d of %0d results arrived", cycles, received, num_vec);
    $display("%0d vectors, %0d received, %0d errors", num_vec, received, errors);
    if (errors == 0 && !timed_out)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== test/fsp_vectors.hex ====
// columns: op fmt src0 src1 expected_data expected_nv expected_special
// op 0 add 1 sub 2 max 3 min 4 feq 5 flt 6 fle, fmt 0 double 1 single
// add and sub
0 0 7FF8000000000123 3FF0000000000000 7FF8000000000000 0 1
0 0 3FF0000000000000 7FF0000000000001 7FF8000000000000 1 1
0 0 7FF0000000000000 FFF0000000000000 7FF8000000000000 1 1
1 0 7FF0000000000000 7FF0000000000000 7FF8000000000000 1 1
0 0 7FF0000000000000 7FF0000000000000 7FF0000000000000 0 1
1 0 FFF0000000000000 7FF0000000000000 FFF0000000000000 0 1
0 0 3FF0000000000000 FFF0000000000000 FFF0000000000000 0 1
1 0 3FF0000000000000 FFF0000000000000 7FF0000000000000 0 1
0 0 7FF0000000000001 7FF8000000000123 7FF8000000000000 1 1
// max and min
2 0 7FF8000000000123 3FF0000000000000 3FF0000000000000 0 1
3 0 BFF0000000000000 7FF8000000000123 BFF0000000000000 0 1
2 0 7FF0000000000001 3FF0000000000000 7FF8000000000000 1 1
3 0 7FF8000000000123 FFF8000000000456 7FF8000000000000 0 1
2 0 3FF0000000000000 7FF0000000000000 7FF0000000000000 0 1
2 0 FFF0000000000000 4000000000000000 4000000000000000 0 1
3 0 FFF0000000000000 4000000000000000 FFF0000000000000 0 1
3 0 7FF0000000000000 BFF0000000000000 BFF0000000000000 0 1
3 0 7FF0000000000000 FFF0000000000000 FFF0000000000000 0 1
// compares
4 0 7FF8000000000123 3FF0000000000000 0000000000000000 0 1
4 0 7FF0000000000001 3FF0000000000000 0000000000000000 1 1
5 0 7FF8000000000123 3FF0000000000000 0000000000000000 1 1
6 0 3FF0000000000000 7FF0000000000001 0000000000000000 1 1
4 0 7FF0000000000000 7FF0000000000000 0000000000000001 0 1
4 0 7FF0000000000000 FFF0000000000000 0000000000000000 0 1
5 0 FFF0000000000000 7FF0000000000000 0000000000000001 0 1
5 0 7FF0000000000000 4000000000000000 0000000000000000 0 1
5 0 4000000000000000 7FF0000000000000 0000000000000001 0 1
6 0 7FF0000000000000 7FF0000000000000 0000000000000001 0 1
6 0 FFF0000000000000 BFF0000000000000 0000000000000001 0 1
// single, boxed with ones
0 1 FFFFFFFF7FC00123 FFFFFFFF3F800000 FFFFFFFF7FC00000 0 1
1 1 FFFFFFFF7F800000 FFFFFFFF7F800000 FFFFFFFF7FC00000 1 1
0 1 FFFFFFFF3F800000 FFFFFFFFFF800000 FFFFFFFFFF800000 0 1
2 1 FFFFFFFF7FC00123 FFFFFFFFC0000000 FFFFFFFFC0000000 0 1
3 1 FFFFFFFF7F800000 FFFFFFFF7F800001 FFFFFFFF7FC00000 1 1
5 1 FFFFFFFFFF800000 FFFFFFFF3F800000 0000000000000001 0 1
6 1 FFFFFFFF7F800001 FFFFFFFF7F800000 0000000000000000 1 1
// finite operands stay with the main adder
0 0 3FF0000000000000 4000000000000000 0000000000000000 0 0
4 1 FFFFFFFF3F800000 FFFFFFFFC0000000 0000000000000000 0 0
2 0 0000000000000000 BFF0000000000000 0000000000000000 0 0

// ==== filelist.f ====
+incdir+include
src/fsp_format_pkg.sv
src/fsp_op_pkg.sv
src/fsp_classify.sv
src/fsp_resolve.sv
src/fsp_assemble.sv
src/fsp_result_buffer.sv
src/fsp_special_top.sv
test/tb_fsp_special.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_fsp_special \
  -f filelist.f

sim_out=$(./obj_dir/Vtb_fsp_special)
echo "$sim_out"

if echo "$sim_out" | grep -qx "SIMULATION PASSED"; then
  exit 0
else
  exit 1
fi
